/* sim.f */
hdl/rvc_pkg.sv
hdl/istream_pkg.sv
hdl/window_if.sv
hdl/lsb_pick.sv
hdl/way_select.sv
hdl/stream_buffer.sv
hdl/istream_top.sv
verification/istream_properties.sv
verification/istream_tb.sv

/* Makefile */
# Verilator build and run of the instruction stream buffer testbench

VERILATOR ?= verilator
TOP       ?= istream_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS RUN_ARGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/istream_tb.sv */
// --------------------------------------------------
// istream_tb
// drives random fetch blocks and checks the picked
// instructions against a chunk-stream model
// --------------------------------------------------
`timescale 1ns/10ps

module istream_tb;
    import rvc_pkg::*;
    import istream_pkg::*;

    localparam int  ISTREAM_SETS   = 4;
    localparam pc_t INIT_PC        = 32'h0001_0000;
    localparam int  TIMEOUT_CYCLES = 200;
    localparam logic [31:0] LFSR_SEED = 32'h1d6d_27cb;
    localparam logic [31:0] LFSR_MASK = 32'h8020_0003;
    localparam pc_t FULL_PC        = 32'h0003_0000;
    localparam pc_t RESTART_PC     = 32'h0004_2a30;

    logic                               CLK;
    logic                               nRST;
    logic                               valid_senq;
    logic [CHUNKS_PER_SET-1:0]          valid_by_chunk_senq;
    chunk_u [CHUNKS_PER_SET-1:0]        instr_by_chunk_senq;
    pc_t                                after_pc_senq;
    logic                               stall_senq;
    logic                               valid_sdeq;
    logic [NUM_WAYS-1:0]                valid_by_way_sdeq;
    logic [NUM_WAYS-1:0]                uncompressed_by_way_sdeq;
    chunk_u [NUM_WAYS-1:0][1:0]         instr_by_way_by_chunk_sdeq;
    pc_t [NUM_WAYS-1:0]                 pc_by_way_sdeq;
    logic                               stall_sdeq;
    logic                               restart;
    pc_t                                restart_pc;

    // valid chunks of the accepted stream in order
    chunk_u      model_chunk[$];
    pc_t         model_pc[$];
    pc_t         model_base;
    int          max_ways;
    bit          first_seen;
    pc_t         first_pc;
    logic [31:0] lfsr_state;
    bit          bp_enable;

    istream_top #(
        .ISTREAM_SETS (ISTREAM_SETS),
        .INIT_PC      (INIT_PC)
    ) DUT (
        .CLK                        (CLK),
        .nRST                       (nRST),
        .valid_senq                 (valid_senq),
        .valid_by_chunk_senq        (valid_by_chunk_senq),
        .instr_by_chunk_senq        (instr_by_chunk_senq),
        .after_pc_senq              (after_pc_senq),
        .stall_senq                 (stall_senq),
        .valid_sdeq                 (valid_sdeq),
        .valid_by_way_sdeq          (valid_by_way_sdeq),
        .uncompressed_by_way_sdeq   (uncompressed_by_way_sdeq),
        .instr_by_way_by_chunk_sdeq (instr_by_way_by_chunk_sdeq),
        .pc_by_way_sdeq             (pc_by_way_sdeq),
        .stall_sdeq                 (stall_sdeq),
        .restart                    (restart),
        .restart_pc                 (restart_pc)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // --------------------------------------------------
    // random source and reference
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_MASK) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // instruction starting at stream position pos
    // returns the chunks it uses or 0 when incomplete
    function automatic int predict_at(input int pos, output chunk_u lo, output chunk_u hi,
                                      output pc_t pc, output bit unc);
        lo = '0;
        hi = '0;
        pc = '0;
        unc = 1'b0;
        if (pos >= model_chunk.size()) begin
            return 0;
        end
        lo = model_chunk[pos];
        pc = model_pc[pos];
        unc = lo.raw[1:0] == 2'b11;
        if (!unc) begin
            return 1;
        end
        // upper half is the next valid chunk in any block
        if (pos + 1 >= model_chunk.size()) begin
            return 0;
        end
        hi = model_chunk[pos+1];
        return 2;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_chunk(input string name, input chunk_u got, input chunk_u exp);
        if (got.raw !== exp.raw) begin
            report_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got.raw, exp.raw));
        end
    endtask

    task automatic check_bit(input string name, input bit got, input bit exp);
        if (got != exp) begin
            report_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // --------------------------------------------------
    // monitor
    // --------------------------------------------------
    task automatic clear_model(input pc_t pc);
        model_chunk.delete();
        model_pc.delete();
        model_base = {pc[31:4], 4'h0};
        first_seen = 1'b0;
    endtask

    task automatic record_block();
        for (int i = 0; i < CHUNKS_PER_SET; i++) begin
            if (valid_by_chunk_senq[i]) begin
                model_chunk.push_back(instr_by_chunk_senq[i]);
                model_pc.push_back(model_base + pc_t'(2 * i));
            end
        end
        model_base = {after_pc_senq[31:4], 4'h0};
    endtask

    task automatic compare_ways();
        int     pos;
        int     used;
        int     ways;
        chunk_u lo;
        chunk_u hi;
        pc_t    pc;
        bit     unc;
        pos = 0;
        ways = 0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_by_way_sdeq[w]) begin
                used = predict_at(pos, lo, hi, pc, unc);
                if (used == 0) begin
                    report_failure($sformatf("way %0d is valid but no instruction is due", w));
                end
                check_pc($sformatf("pc_by_way_sdeq[%0d]", w), pc_by_way_sdeq[w], pc);
                check_bit($sformatf("uncompressed_by_way_sdeq[%0d]", w),
                          uncompressed_by_way_sdeq[w], unc);
                check_chunk($sformatf("instr_by_way_by_chunk_sdeq[%0d][0]", w),
                            instr_by_way_by_chunk_sdeq[w][0], lo);
                if (unc) begin
                    check_chunk($sformatf("instr_by_way_by_chunk_sdeq[%0d][1]", w),
                                instr_by_way_by_chunk_sdeq[w][1], hi);
                end
                pos += used;
                ways++;
            end
        end
        if (ways > max_ways) begin
            max_ways = ways;
        end
        // consumed at the coming edge
        if (!stall_sdeq && !restart && ways > 0) begin
            if (!first_seen) begin
                first_seen = 1'b1;
                first_pc = pc_by_way_sdeq[0];
            end
            repeat (pos) begin
                void'(model_chunk.pop_front());
                void'(model_pc.pop_front());
            end
        end
    endtask

    always @(negedge CLK) begin
        if (!nRST) begin
            clear_model(INIT_PC);
        end else begin
            compare_ways();
            if (DUT.u_props.fail_count != 0) begin
                report_failure("a bound assertion on the DUT ports failed");
            end
            if (restart) begin
                clear_model(restart_pc);
            end else if (valid_senq && !stall_senq) begin
                record_block();
            end
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    // tasks start and end just after a rising edge
    task automatic drive_backpressure();
        if (bp_enable) begin
            stall_sdeq <= rand_bits(1) != 0;
        end
    endtask

    task automatic push_random_block(input bit compressed_only, input bit all_valid,
                                     output int waited);
        chunk_u [CHUNKS_PER_SET-1:0] blk;
        logic [CHUNKS_PER_SET-1:0]   mask;
        logic [15:0]                 raw;
        if (bp_enable && rand_bits(2) == 0) begin
            valid_senq <= 1'b0;
            drive_backpressure();
            @(posedge CLK);
        end
        for (int i = 0; i < CHUNKS_PER_SET; i++) begin
            raw = 16'(rand_bits(16));
            if (compressed_only && raw[1:0] == 2'b11) begin
                raw[0] = 1'b0;
            end else if (!compressed_only && rand_bits(1) != 0) begin
                raw[1:0] = 2'b11;
            end
            blk[i].raw = raw;
        end
        mask = all_valid ? 8'hFF : 8'(rand_bits(8));
        // an empty block never carries an instruction
        if (mask == '0) begin
            mask = 8'h80;
        end
        valid_senq          <= 1'b1;
        valid_by_chunk_senq <= mask;
        instr_by_chunk_senq <= blk;
        after_pc_senq       <= pc_t'(rand_bits(28)) << 4;
        drive_backpressure();
        waited = 0;
        @(negedge CLK);
        while (stall_senq) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_failure("stall_senq stayed high while a block was waiting");
            end
            @(posedge CLK);
            drive_backpressure();
            @(negedge CLK);
        end
        @(posedge CLK);
    endtask

    task automatic restart_to(input pc_t pc);
        valid_senq <= 1'b0;
        restart    <= 1'b1;
        restart_pc <= pc;
        @(posedge CLK);
        restart    <= 1'b0;
    endtask

    task automatic wait_drained();
        int     cycles;
        chunk_u lo;
        chunk_u hi;
        pc_t    pc;
        bit     unc;
        cycles = 0;
        // the model settles at the falling edge
        while (predict_at(0, lo, hi, pc, unc) != 0) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_failure("queued instructions did not drain in time");
            end
            @(posedge CLK);
        end
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        int waited;
        nRST                = 1'b0;
        valid_senq          = 1'b0;
        valid_by_chunk_senq = '0;
        instr_by_chunk_senq = '0;
        after_pc_senq       = '0;
        stall_sdeq          = 1'b0;
        restart             = 1'b0;
        restart_pc          = '0;
        lfsr_state          = LFSR_SEED;
        bp_enable           = 1'b0;
        max_ways            = 0;
        first_pc            = '0;

        repeat (5) @(posedge CLK);
        nRST <= 1'b1;

        // idle after reset
        @(negedge CLK);
        check_bit("stall_senq", stall_senq, 1'b0);
        check_bit("valid_sdeq", valid_sdeq, 1'b0);
        for (int w = 0; w < NUM_WAYS; w++) begin
            check_bit($sformatf("valid_by_way_sdeq[%0d]", w), valid_by_way_sdeq[w], 1'b0);
        end
        @(posedge CLK);

        // compressed only with the first blocks held back so four ways line up
        stall_sdeq <= 1'b1;
        push_random_block(1'b1, 1'b1, waited);
        for (int i = 0; i < 3; i++) begin
            push_random_block(1'b1, 1'b0, waited);
        end
        stall_sdeq <= 1'b0;
        for (int i = 0; i < 36; i++) begin
            push_random_block(1'b1, 1'b0, waited);
        end
        valid_senq <= 1'b0;
        wait_drained();
        if (max_ways != NUM_WAYS) begin
            report_failure("four instructions were never picked in one cycle");
        end

        // mixed lengths with upper halves crossing blocks
        for (int i = 0; i < 40; i++) begin
            push_random_block(1'b0, 1'b0, waited);
        end
        valid_senq <= 1'b0;
        wait_drained();

        // fill up with the dequeue side stalled
        restart_to(FULL_PC);
        stall_sdeq <= 1'b1;
        for (int i = 0; i < ISTREAM_SETS; i++) begin
            push_random_block(1'b0, 1'b0, waited);
            if (waited != 0) begin
                report_failure("stall_senq rose before the buffer was full");
            end
        end
        valid_senq <= 1'b0;
        @(negedge CLK);
        check_bit("stall_senq", stall_senq, 1'b1);
        @(posedge CLK);
        stall_sdeq <= 1'b0;
        wait_drained();

        // random back-pressure on both sides
        bp_enable = 1'b1;
        for (int i = 0; i < 60; i++) begin
            push_random_block(1'b0, 1'b0, waited);
        end
        bp_enable = 1'b0;
        stall_sdeq <= 1'b0;
        valid_senq <= 1'b0;
        wait_drained();

        // restart drops queued blocks
        stall_sdeq <= 1'b1;
        for (int i = 0; i < 3; i++) begin
            push_random_block(1'b0, 1'b0, waited);
        end
        restart_to(RESTART_PC);
        @(negedge CLK);
        check_bit("valid_sdeq", valid_sdeq, 1'b0);
        check_bit("stall_senq", stall_senq, 1'b0);
        @(posedge CLK);
        stall_sdeq <= 1'b0;
        push_random_block(1'b0, 1'b1, waited);
        for (int i = 0; i < 10; i++) begin
            push_random_block(1'b0, 1'b0, waited);
        end
        valid_senq <= 1'b0;
        wait_drained();
        if (!first_seen) begin
            report_failure("no instruction came out after the restart");
        end
        check_pc("first pc after restart", first_pc, RESTART_PC);

        if (DUT.u_props.fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            report_failure("a bound assertion on the DUT ports failed");
        end
    end

endmodule

/* verification/istream_properties.sv */
// --------------------------------------------------
// istream_properties
// port-level checks on the dequeue side of the
// instruction stream buffer
// --------------------------------------------------
`timescale 1ns/10ps

module istream_properties (
    input logic                                       CLK,
    input logic                                       nRST,
    input logic                                       stall_sdeq,
    input logic                                       restart,
    input logic                                       valid_sdeq,
    input logic [istream_pkg::NUM_WAYS-1:0]           valid_by_way_sdeq,
    input istream_pkg::pc_t [istream_pkg::NUM_WAYS-1:0] pc_by_way_sdeq
);
    import istream_pkg::*;

    int unsigned contig_errors = 0;
    int unsigned valid0_errors = 0;
    int unsigned hold_errors   = 0;
    int unsigned fail_count;

    // total seen by the testbench
    assign fail_count = contig_errors + valid0_errors + hold_errors;

    // ways form a run of ones from way 0
    a_contiguous: assert property (@(posedge CLK) disable iff (!nRST)
        (valid_by_way_sdeq & (valid_by_way_sdeq + 1'b1)) == '0)
    else begin
        contig_errors++;
        $error("valid ways are not contiguous from way 0");
    end

    a_valid_way0: assert property (@(posedge CLK) disable iff (!nRST)
        valid_sdeq == valid_by_way_sdeq[0])
    else begin
        valid0_errors++;
        $error("valid_sdeq differs from way 0 valid");
    end

    // a stalled head instruction must not move
    a_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (stall_sdeq && valid_sdeq && !restart) |=>
            (valid_by_way_sdeq[0] && pc_by_way_sdeq[0] == $past(pc_by_way_sdeq[0])))
    else begin
        hold_errors++;
        $error("way 0 changed while the dequeue side was stalled");
    end

endmodule

bind istream_top istream_properties u_props (
    .CLK               (CLK),
    .nRST              (nRST),
    .stall_sdeq        (stall_sdeq),
    .restart           (restart),
    .valid_sdeq        (valid_sdeq),
    .valid_by_way_sdeq (valid_by_way_sdeq),
    .pc_by_way_sdeq    (pc_by_way_sdeq)
);

/* hdl/istream_top.sv */
// --------------------------------------------------
// istream_top
// fetch-to-decode instruction stream buffer
// --------------------------------------------------
`timescale 1ns/10ps

module istream_top #(
    parameter int               ISTREAM_SETS = 8,
    parameter istream_pkg::pc_t INIT_PC      = 32'h8000_0000
) (
    input  logic                                      CLK,
    input  logic                                      nRST,

    // enqueue side
    input  logic                                      valid_senq,
    input  logic [istream_pkg::CHUNKS_PER_SET-1:0]    valid_by_chunk_senq,
    input  rvc_pkg::chunk_u [istream_pkg::CHUNKS_PER_SET-1:0] instr_by_chunk_senq,
    input  istream_pkg::pc_t                          after_pc_senq,
    output logic                                      stall_senq,

    // dequeue side
    output logic                                      valid_sdeq,
    output logic [istream_pkg::NUM_WAYS-1:0]          valid_by_way_sdeq,
    output logic [istream_pkg::NUM_WAYS-1:0]          uncompressed_by_way_sdeq,
    output rvc_pkg::chunk_u [istream_pkg::NUM_WAYS-1:0][1:0] instr_by_way_by_chunk_sdeq,
    output istream_pkg::pc_t [istream_pkg::NUM_WAYS-1:0]     pc_by_way_sdeq,
    input  logic                                      stall_sdeq,

    // redirect
    input  logic                                      restart,
    input  istream_pkg::pc_t                          restart_pc
);

    window_if win ();

    stream_buffer #(
        .ISTREAM_SETS (ISTREAM_SETS),
        .INIT_PC      (INIT_PC)
    ) u_buffer (
        .CLK                 (CLK),
        .nRST                (nRST),
        .valid_senq          (valid_senq),
        .valid_by_chunk_senq (valid_by_chunk_senq),
        .instr_by_chunk_senq (instr_by_chunk_senq),
        .after_pc_senq       (after_pc_senq),
        .stall_senq          (stall_senq),
        .stall_sdeq          (stall_sdeq),
        .restart             (restart),
        .restart_pc          (restart_pc),
        .win                 (win.buffer)
    );

    way_select u_select (
        .win                        (win.picker),
        .valid_sdeq                 (valid_sdeq),
        .valid_by_way_sdeq          (valid_by_way_sdeq),
        .uncompressed_by_way_sdeq   (uncompressed_by_way_sdeq),
        .instr_by_way_by_chunk_sdeq (instr_by_way_by_chunk_sdeq),
        .pc_by_way_sdeq             (pc_by_way_sdeq)
    );

endmodule

/* hdl/stream_buffer.sv */
// --------------------------------------------------
// stream_buffer
// circular set FIFO of fetch blocks, presents the two
// oldest sets and retires them as they are consumed
// --------------------------------------------------
`timescale 1ns/10ps

module stream_buffer #(
    parameter int               ISTREAM_SETS = 8,
    parameter istream_pkg::pc_t INIT_PC      = 32'h8000_0000
) (
    input  logic                                      CLK,
    input  logic                                      nRST,
    input  logic                                      valid_senq,
    input  logic [istream_pkg::CHUNKS_PER_SET-1:0]    valid_by_chunk_senq,
    input  rvc_pkg::chunk_u [istream_pkg::CHUNKS_PER_SET-1:0] instr_by_chunk_senq,
    input  istream_pkg::pc_t                          after_pc_senq,
    output logic                                      stall_senq,
    input  logic                                      stall_sdeq,
    input  logic                                      restart,
    input  istream_pkg::pc_t                          restart_pc,
    window_if.buffer                                  win
);
    import rvc_pkg::*;
    import istream_pkg::*;

    localparam int IDX_BITS = $clog2(ISTREAM_SETS);

    typedef struct packed {
        logic                wrap;
        logic [IDX_BITS-1:0] idx;
    } set_ptr_t;

    // payload
    chunk_u [CHUNKS_PER_SET-1:0] chunk_mem [ISTREAM_SETS];
    pc28_t                       after_mem [ISTREAM_SETS];

    // per-chunk valid bits, cleared as chunks are picked
    logic [ISTREAM_SETS-1:0][CHUNKS_PER_SET-1:0] valid_q, valid_next;

    set_ptr_t enq_ptr, enq_next;
    set_ptr_t deq0_ptr, deq0_next;
    set_ptr_t deq1_ptr, deq1_next;
    pc28_t    base_q, base_next;

    logic full;
    logic empty0;
    logic empty1;
    logic enq_fire;
    logic set0_done;
    logic set1_done;

    // --------------------------------------------------
    // status and window
    // --------------------------------------------------
    assign full   = (enq_ptr.idx == deq0_ptr.idx) & (enq_ptr.wrap != deq0_ptr.wrap);
    assign empty0 = enq_ptr == deq0_ptr;
    // fewer than two sets held
    assign empty1 = empty0 | (enq_ptr == deq1_ptr);

    assign stall_senq = full;
    assign enq_fire   = valid_senq & ~full;

    always_comb begin
        for (int i = 0; i < CHUNKS_PER_SET; i++) begin
            win.win_valid[i] = valid_q[deq0_ptr.idx][i] & ~empty0;
            win.win_valid[i+CHUNKS_PER_SET] = valid_q[deq1_ptr.idx][i] & ~empty1;
            win.win_chunk[i] = chunk_mem[deq0_ptr.idx][i];
            win.win_chunk[i+CHUNKS_PER_SET] = chunk_mem[deq1_ptr.idx][i];
        end
    end

    // set 1 starts where set 0's block ends
    assign win.set0_base = base_q;
    assign win.set1_base = after_mem[deq0_ptr.idx];

    // a held set is done once every valid chunk is acked
    assign set0_done = ~empty0 &
        ~|(win.win_valid[CHUNKS_PER_SET-1:0] & ~win.ack_vec[CHUNKS_PER_SET-1:0]);
    assign set1_done = ~empty1 &
        ~|(win.win_valid[WINDOW_CHUNKS-1:CHUNKS_PER_SET] &
           ~win.ack_vec[WINDOW_CHUNKS-1:CHUNKS_PER_SET]);

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        valid_next = valid_q;
        enq_next   = enq_ptr;
        deq0_next  = deq0_ptr;
        deq1_next  = deq1_ptr;
        base_next  = base_q;

        if (!stall_sdeq) begin
            valid_next[deq0_ptr.idx] = valid_q[deq0_ptr.idx] &
                ~win.ack_vec[CHUNKS_PER_SET-1:0];
            valid_next[deq1_ptr.idx] = valid_q[deq1_ptr.idx] &
                ~win.ack_vec[WINDOW_CHUNKS-1:CHUNKS_PER_SET];

            // retire one or two sets
            if (set0_done && set1_done) begin
                deq0_next = set_ptr_t'(deq0_ptr + 2'd2);
                deq1_next = set_ptr_t'(deq1_ptr + 2'd2);
                base_next = after_mem[deq1_ptr.idx];
            end else if (set0_done) begin
                deq0_next = set_ptr_t'(deq0_ptr + 1'b1);
                deq1_next = set_ptr_t'(deq1_ptr + 1'b1);
                base_next = after_mem[deq0_ptr.idx];
            end
        end

        if (enq_fire) begin
            valid_next[enq_ptr.idx] = valid_by_chunk_senq;
            enq_next = set_ptr_t'(enq_ptr + 1'b1);
        end
    end

    // --------------------------------------------------
    // registers
    // --------------------------------------------------
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q  <= '0;
            enq_ptr  <= '0;
            deq0_ptr <= '0;
            deq1_ptr <= set_ptr_t'(1);
            base_q   <= pc28_t'(INIT_PC >> BASE_LSB);
        end else if (restart) begin
            // flush everything, new stream starts at restart_pc
            valid_q  <= '0;
            enq_ptr  <= '0;
            deq0_ptr <= '0;
            deq1_ptr <= set_ptr_t'(1);
            base_q   <= pc28_t'(restart_pc >> BASE_LSB);
        end else begin
            valid_q  <= valid_next;
            enq_ptr  <= enq_next;
            deq0_ptr <= deq0_next;
            deq1_ptr <= deq1_next;
            base_q   <= base_next;
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            chunk_mem[enq_ptr.idx] <= instr_by_chunk_senq;
            after_mem[enq_ptr.idx] <= pc28_t'(after_pc_senq >> BASE_LSB);
        end
    end

endmodule

/* hdl/way_select.sv */
// --------------------------------------------------
// way_select
// picks up to four in-order instructions from the
// window and forms their PCs
// --------------------------------------------------
`timescale 1ns/10ps

module way_select (
    window_if.picker                          win,
    output logic                              valid_sdeq,
    output logic [istream_pkg::NUM_WAYS-1:0]  valid_by_way_sdeq,
    output logic [istream_pkg::NUM_WAYS-1:0]  uncompressed_by_way_sdeq,
    output rvc_pkg::chunk_u [istream_pkg::NUM_WAYS-1:0][1:0] instr_by_way_by_chunk_sdeq,
    output istream_pkg::pc_t [istream_pkg::NUM_WAYS-1:0]     pc_by_way_sdeq
);
    import rvc_pkg::*;
    import istream_pkg::*;

    logic [NUM_WAYS-1:0][WINDOW_CHUNKS-1:0] lower_req;
    logic [NUM_WAYS-1:0][WINDOW_CHUNKS-1:0] lower_cold;
    logic [NUM_WAYS-1:0][WINDOW_CHUNKS-1:0] upper_req;
    logic [NUM_WAYS-1:0][WINDOW_CHUNKS-1:0] upper_cold;
    win_idx_t [NUM_WAYS-1:0]                lower_idx;
    win_idx_t [NUM_WAYS-1:0]                upper_idx;
    logic [NUM_WAYS-1:0]                    lower_present;
    logic [NUM_WAYS-1:0]                    upper_present;
    logic [NUM_WAYS-1:0]                    lower_uncomp;
    logic [NUM_WAYS-1:0]                    way_valid;

    // --------------------------------------------------
    // way chain
    // --------------------------------------------------
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        if (w == 0) begin : g_first
            assign lower_req[w] = win.win_valid;
        end else begin : g_next
            // resume after the previous way's last chunk
            assign lower_req[w] = lower_uncomp[w-1] ? (upper_cold[w-1] & win.win_valid)
                                                    : (lower_cold[w-1] & win.win_valid);
        end

        lsb_pick #(
            .WIDTH(WINDOW_CHUNKS)
        ) u_lower (
            .req_vec   (lower_req[w]),
            .present   (lower_present[w]),
            .index     (lower_idx[w]),
            .cold_mask (lower_cold[w])
        );

        // upper half is the next valid chunk, possibly in set 1
        assign upper_req[w] = lower_cold[w] & win.win_valid;

        lsb_pick #(
            .WIDTH(WINDOW_CHUNKS)
        ) u_upper (
            .req_vec   (upper_req[w]),
            .present   (upper_present[w]),
            .index     (upper_idx[w]),
            .cold_mask (upper_cold[w])
        );

        assign lower_uncomp[w] = win.win_chunk[lower_idx[w]].enc.len_code == LEN_UNCOMPRESSED;

        // missing upper half fails the way, later ways see no requests
        assign way_valid[w] = lower_present[w] & (~lower_uncomp[w] | upper_present[w]);
    end

    // --------------------------------------------------
    // acks and outputs
    // --------------------------------------------------
    always_comb begin
        win.ack_vec = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_valid[w]) begin
                win.ack_vec[lower_idx[w]] = 1'b1;
                if (lower_uncomp[w]) begin
                    win.ack_vec[upper_idx[w]] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            uncompressed_by_way_sdeq[w] = lower_uncomp[w];
            instr_by_way_by_chunk_sdeq[w][0].raw = win.win_chunk[lower_idx[w]].raw;
            instr_by_way_by_chunk_sdeq[w][1].raw = win.win_chunk[upper_idx[w]].raw;
            // set base from the lower chunk's set, then chunk offset
            pc_by_way_sdeq[w] = {
                lower_idx[w][CHUNK_IDX_BITS] ? win.set1_base : win.set0_base,
                lower_idx[w][CHUNK_IDX_BITS-1:0],
                1'b0
            };
        end
    end

    assign valid_by_way_sdeq = way_valid;
    assign valid_sdeq        = way_valid[0];

endmodule

/* hdl/lsb_pick.sv */
// --------------------------------------------------
// lsb_pick
// lowest set bit picker with index and cold mask
// --------------------------------------------------
`timescale 1ns/10ps

module lsb_pick #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0]       req_vec,
    output logic                   present,
    output istream_pkg::win_idx_t  index,
    output logic [WIDTH-1:0]       cold_mask
);
    import istream_pkg::*;

    logic [WIDTH-1:0] one_hot;

    // isolate lowest request
    assign one_hot = req_vec & (~req_vec + 1'b1);

    assign present = |req_vec;

    // everything above the picked bit
    // no request gives an all-zero mask
    assign cold_mask = ~(one_hot | (one_hot - 1'b1));

    always_comb begin
        index = '0;
        // descending so the lowest request wins
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                index = win_idx_t'(i);
            end
        end
    end

endmodule

/* hdl/window_if.sv */
// --------------------------------------------------
// window_if
// dequeue window from buffer to picker, acks back
// --------------------------------------------------
`timescale 1ns/10ps

interface window_if;
    import rvc_pkg::*;
    import istream_pkg::*;

    // two oldest sets, set 0 in the low half
    logic [WINDOW_CHUNKS-1:0]   win_valid;
    chunk_u [WINDOW_CHUNKS-1:0] win_chunk;
    pc28_t                      set0_base;
    pc28_t                      set1_base;

    // chunks consumed by the picked ways this cycle
    logic [WINDOW_CHUNKS-1:0]   ack_vec;

    modport buffer (
        output win_valid, win_chunk, set0_base, set1_base,
        input  ack_vec
    );

    modport picker (
        input  win_valid, win_chunk, set0_base, set1_base,
        output ack_vec
    );

endinterface

/* hdl/istream_pkg.sv */
// --------------------------------------------------
// istream_pkg
// stream buffer geometry and PC field types
// --------------------------------------------------
package istream_pkg;

    // one fetch block is eight chunks
    localparam int CHUNKS_PER_SET = 8;

    // two oldest sets side by side
    localparam int WINDOW_CHUNKS = 2 * CHUNKS_PER_SET;

    // instructions handed to decode per cycle
    localparam int NUM_WAYS = 4;

    // chunk position bits inside a set
    localparam int CHUNK_IDX_BITS = $clog2(CHUNKS_PER_SET);

    // lowest PC bit of the block-aligned base
    localparam int BASE_LSB = CHUNK_IDX_BITS + 1;

    // window chunk index, top bit selects set 1
    typedef logic [$clog2(WINDOW_CHUNKS)-1:0] win_idx_t;

    typedef logic [31:0] pc_t;
    typedef logic [31-BASE_LSB:0] pc28_t;

endpackage

/* hdl/rvc_pkg.sv */
// --------------------------------------------------
// rvc_pkg
// RISC-V instruction chunk encoding and length code
// --------------------------------------------------
package rvc_pkg;

    // one 2-byte slice of a fetch block
    localparam int CHUNK_BITS = 16;

    // low bits of a chunk that start a 4-byte instruction
    localparam logic [1:0] LEN_UNCOMPRESSED = 2'b11;

    // decoded view, only the length code matters here
    typedef struct packed {
        logic [CHUNK_BITS-3:0] upper_bits;
        logic [1:0]            len_code;
    } chunk_enc_t;

    // raw halfword for the output, enc view for the length test
    typedef union packed {
        logic [CHUNK_BITS-1:0] raw;
        chunk_enc_t            enc;
    } chunk_u;

endpackage
